//--- common/i2c_host_pkg.sv
`default_nettype none

// types and constants shared by the i2c host sequencer blocks
package i2c_host_pkg;

	typedef logic [2:0]  wb_adr_t;     // core register select
	typedef logic [7:0]  wb_byte_t;    // one bus data byte
	typedef logic [15:0] prescale_t;   // scl prescale value
	typedef logic [6:0]  slave_addr_t; // 7-bit i2c address
	typedef logic [3:0]  byte_cnt_t;   // byte count / length

	// control word from the host memory, msb first
	typedef struct packed {
		prescale_t   prescale;     // [31:16]
		logic        unused;       // [15]
		byte_cnt_t   length;       // [14:11] data bytes for a write
		slave_addr_t slave_addr;   // [10:4]
		logic        set_prescale; // [3]
		logic        wr;           // [2]
		logic        rd;           // [1] not handled
		logic        start;        // [0]
	} ctrl_word_t;

	// bus access asked for by the sequencer in one cycle
	typedef enum logic [3:0] {
		REQ_NONE,
		REQ_ADDR,
		REQ_DATA,
		REQ_CMD_START_WRITE,
		REQ_CMD_RESTART,
		REQ_CMD_STOP,
		REQ_STATUS,
		REQ_PRESC_LO,
		REQ_PRESC_HI,
		REQ_RELEASE
	} req_kind_t;

	typedef enum logic [1:0] {
		CNT_HOLD,
		CNT_CLEAR,
		CNT_LOADED_INC,
		CNT_SENT_INC
	} cnt_op_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_ADDR,      // put slave address on the bus
		S_LOAD,      // fill the write fifo
		S_START_ACK, // start-write or restart in flight
		S_BUSY_HI,   // poll until core goes busy
		S_BUSY_LO,   // poll until byte done
		S_STOP,      // final stop in flight
		S_ABORT,     // stop after missed ack
		S_PRESC_LO,
		S_PRESC_HI,
		S_PRESC_REL,
		S_DONE
	} seq_state_t;

	// core register map
	localparam wb_adr_t REG_STATUS   = 3'd0;
	localparam wb_adr_t REG_ADDR     = 3'd2;
	localparam wb_adr_t REG_CMD      = 3'd3;
	localparam wb_adr_t REG_DATA     = 3'd4;
	localparam wb_adr_t REG_PRESC_LO = 3'd6;
	localparam wb_adr_t REG_PRESC_HI = 3'd7;

	// command register values
	localparam wb_byte_t CMD_START_WRITE = 8'h05; // start + write
	localparam wb_byte_t CMD_RESTART     = 8'h04;
	localparam wb_byte_t CMD_STOP        = 8'h10;

	// status register bits
	localparam int STAT_BUSY     = 0;
	localparam int STAT_MISS_ACK = 3;

endpackage

`default_nettype wire

//--- rtl/i2c_seq/i2c_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// command fsm
// walks through the core register accesses for set-prescale and write,
// one bus request per ack, polling status between bytes
module i2c_seq_fsm
	import i2c_host_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  ctrl_word_t ctrl_i,       // level, decoded in idle only
	input  logic       ack_i,        // from the core
	input  wb_byte_t   status_i,     // core read data
	input  logic       all_loaded_i, // every byte in the write fifo
	input  logic       all_sent_i,   // every byte went busy
	output req_kind_t  req_o,        // registered by the driver
	output cnt_op_t    cnt_op_o,
	output logic       capture_o,    // latch control and data words
	output logic       done_o,
	output logic       busy_o
);

	seq_state_t state;
	seq_state_t state_nxt;
	logic       stat_busy; // core transferring a byte
	logic       stat_miss; // slave did not ack

	assign stat_busy = status_i[STAT_BUSY];
	assign stat_miss = status_i[STAT_MISS_ACK];

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		req_o     = REQ_NONE;
		cnt_op_o  = CNT_HOLD;
		capture_o = 1'b0;

		case (state)
			S_IDLE: begin
				// wr wins over set_prescale, rd alone is dropped
				if (ctrl_i.start && ctrl_i.wr) begin
					capture_o = 1'b1;
					cnt_op_o  = CNT_CLEAR;
					state_nxt = S_ADDR;
				end else if (ctrl_i.start && ctrl_i.set_prescale) begin
					capture_o = 1'b1;
					cnt_op_o  = CNT_CLEAR;
					state_nxt = S_PRESC_LO;
				end
			end

			S_ADDR: begin
				req_o     = REQ_ADDR; // captured address now valid
				state_nxt = S_LOAD;
			end

			S_LOAD: begin
				if (ack_i) begin
					if (!all_loaded_i) begin
						// next fifo byte, stay here
						req_o    = REQ_DATA;
						cnt_op_o = CNT_LOADED_INC;
					end else begin
						req_o     = REQ_CMD_START_WRITE;
						state_nxt = S_START_ACK;
					end
				end
			end

			// start-write or restart acked, begin polling
			S_START_ACK: begin
				if (ack_i) begin
					req_o     = REQ_STATUS;
					state_nxt = S_BUSY_HI;
				end
			end

			S_BUSY_HI: begin
				if (ack_i) begin
					if (stat_busy) begin
						// byte is on the wire
						req_o     = REQ_STATUS;
						cnt_op_o  = CNT_SENT_INC;
						state_nxt = S_BUSY_LO;
					end else if (stat_miss) begin
						req_o     = REQ_CMD_STOP; // give up early
						state_nxt = S_ABORT;
					end else begin
						req_o = REQ_STATUS; // not started yet
					end
				end
			end

			S_BUSY_LO: begin
				if (ack_i) begin
					if (stat_busy) begin
						req_o = REQ_STATUS;
					end else if (stat_miss) begin
						req_o     = REQ_CMD_STOP;
						state_nxt = S_ABORT;
					end else if (all_sent_i) begin
						req_o     = REQ_CMD_STOP; // last byte done
						state_nxt = S_STOP;
					end else begin
						req_o     = REQ_CMD_RESTART;
						state_nxt = S_START_ACK;
					end
				end
			end

			S_STOP: begin
				if (ack_i) begin
					req_o     = REQ_RELEASE;
					state_nxt = S_DONE;
				end
			end

			// no done after a missed ack
			S_ABORT: begin
				if (ack_i) begin
					req_o     = REQ_RELEASE;
					state_nxt = S_IDLE;
				end
			end

			// prescale writes go out back to back, acks ignored
			S_PRESC_LO: begin
				req_o     = REQ_PRESC_LO;
				state_nxt = S_PRESC_HI;
			end

			S_PRESC_HI: begin
				req_o     = REQ_PRESC_HI;
				state_nxt = S_PRESC_REL;
			end

			S_PRESC_REL: begin
				req_o     = REQ_RELEASE;
				state_nxt = S_DONE;
			end

			S_DONE: begin
				state_nxt = S_IDLE; // one cycle only
			end

			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	assign done_o = (state == S_DONE);

	// write path only, prescale stays quiet
	assign busy_o = state inside {S_ADDR, S_LOAD, S_START_ACK, S_BUSY_HI,
		S_BUSY_LO, S_STOP, S_ABORT};

endmodule

`default_nettype wire

//--- rtl/i2c_seq/i2c_byte_counter.sv
`timescale 1ns/1ps
`default_nettype none

// loaded and sent byte counts against the captured write length
module i2c_byte_counter
	import i2c_host_pkg::*;
#(
	parameter int DATA_BYTES = 4
) (
	input  logic      clk,
	input  logic      nrst,
	input  cnt_op_t   cnt_op_i,
	input  logic      capture_i,
	input  byte_cnt_t length_i,     // raw field from the control word
	output logic      all_loaded_o,
	output logic      all_sent_o
);

	localparam byte_cnt_t MAX_LEN = byte_cnt_t'(DATA_BYTES);

	byte_cnt_t len;         // clamped length
	byte_cnt_t len_clamped;
	byte_cnt_t loaded_cnt;  // bytes pushed into the write fifo
	byte_cnt_t sent_cnt;    // bytes the core started

	// keep the length inside 1..DATA_BYTES
	always_comb begin
		if (length_i == '0) begin
			len_clamped = byte_cnt_t'(1); // zero sends one byte
		end else if (length_i > MAX_LEN) begin
			len_clamped = MAX_LEN;
		end else begin
			len_clamped = length_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			len        <= byte_cnt_t'(1);
			loaded_cnt <= '0;
			sent_cnt   <= '0;
		end else begin
			if (capture_i) begin
				len <= len_clamped;
			end
			case (cnt_op_i)
				CNT_CLEAR: begin
					loaded_cnt <= '0;
					sent_cnt   <= '0;
				end
				CNT_LOADED_INC: loaded_cnt <= loaded_cnt + 1'b1;
				CNT_SENT_INC:   sent_cnt   <= sent_cnt + 1'b1;
				default: ;      // hold
			endcase
		end
	end

	assign all_loaded_o = (loaded_cnt == len);
	assign all_sent_o   = (sent_cnt == len);

endmodule

`default_nettype wire

//--- rtl/wb_req_driver.sv
`timescale 1ns/1ps
`default_nettype none

// registered bus master side
// turns a request kind into adr/dat/we with a one-cycle stb
module wb_req_driver
	import i2c_host_pkg::*;
#(
	parameter int DATA_BYTES = 4
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  req_kind_t               req_i,
	input  logic                    capture_i,
	input  ctrl_word_t              ctrl_i,
	input  logic [DATA_BYTES*8-1:0] data_i,
	output wb_adr_t                 wbm_adr_o,
	output wb_byte_t                wbm_dat_o,
	output logic                    wbm_we_o,
	output logic                    wbm_stb_o,
	output logic                    wbm_cyc_o
);

	// one bus access as it goes out
	typedef struct packed {
		wb_adr_t  adr;
		wb_byte_t dat;
		logic     we;
	} bus_word_t;

	slave_addr_t             slave_addr; // latched on capture
	prescale_t               prescale;
	logic [DATA_BYTES*8-1:0] tx_buf;     // byte 0 is next to send
	bus_word_t               word;

	// request kind to register, byte and direction
	always_comb begin
		word = '0;
		case (req_i)
			REQ_ADDR: begin
				word.adr = REG_ADDR;
				word.dat = {1'b0, slave_addr};
				word.we  = 1'b1;
			end
			REQ_DATA: begin
				word.adr = REG_DATA;
				word.dat = tx_buf[7:0];
				word.we  = 1'b1;
			end
			REQ_CMD_START_WRITE: begin
				word.adr = REG_CMD;
				word.dat = CMD_START_WRITE;
				word.we  = 1'b1;
			end
			REQ_CMD_RESTART: begin
				word.adr = REG_CMD;
				word.dat = CMD_RESTART;
				word.we  = 1'b1;
			end
			REQ_CMD_STOP: begin
				word.adr = REG_CMD;
				word.dat = CMD_STOP;
				word.we  = 1'b1;
			end
			REQ_STATUS:   word.adr = REG_STATUS; // read, we stays low
			REQ_PRESC_LO: begin
				word.adr = REG_PRESC_LO;
				word.dat = prescale[7:0];
				word.we  = 1'b1;
			end
			REQ_PRESC_HI: begin
				word.adr = REG_PRESC_HI;
				word.dat = prescale[15:8];
				word.we  = 1'b1;
			end
			default: ; // none or release, all zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wbm_adr_o <= '0;
			wbm_dat_o <= '0;
			wbm_we_o  <= 1'b0;
			wbm_stb_o <= 1'b0;
			wbm_cyc_o <= 1'b0;
		end else begin
			case (req_i)
				REQ_NONE: wbm_stb_o <= 1'b0; // cyc and the rest held
				REQ_RELEASE: begin
					{wbm_adr_o, wbm_dat_o, wbm_we_o} <= '0;
					wbm_stb_o <= 1'b0;
					wbm_cyc_o <= 1'b0;
				end
				default: begin
					{wbm_adr_o, wbm_dat_o, wbm_we_o} <= word;
					wbm_stb_o <= 1'b1; // single cycle strobe
					wbm_cyc_o <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture_i) begin
			slave_addr <= ctrl_i.slave_addr;
			prescale   <= ctrl_i.prescale;
			tx_buf     <= data_i;
		end else if (req_i == REQ_DATA) begin
			tx_buf <= tx_buf >> 8; // next byte down, zero fill
		end
	end

endmodule

`default_nettype wire

//--- rtl/i2c_host_top.sv
`timescale 1ns/1ps
`default_nettype none

// i2c host sequencer, drives the register bus of a byte-oriented i2c master core
module i2c_host_top
	import i2c_host_pkg::*;
#(
	parameter int DATA_BYTES = 4 // width of the data word in bytes
) (
	input  logic                    clk,
	input  logic                    nrst,

	// host side
	input  ctrl_word_t              ctrl_i,
	input  logic [DATA_BYTES*8-1:0] data_i,  // lsb byte goes out first
	output logic                    done_o,
	output logic                    busy_o,

	// bus to the i2c master core
	output wb_adr_t                 wbm_adr_o,
	output wb_byte_t                wbm_dat_o,
	input  wb_byte_t                wbm_dat_i,
	output logic                    wbm_we_o,
	output logic                    wbm_stb_o,
	input  logic                    wbm_ack_i,
	output logic                    wbm_cyc_o
);

	req_kind_t req;        // request for this cycle
	cnt_op_t   cnt_op;
	logic      capture;    // command accepted in idle
	logic      all_loaded;
	logic      all_sent;

	// sequencer, the only block that sees ack and read data
	i2c_seq_fsm i_i2c_seq_fsm (
		.clk          (clk),
		.nrst         (nrst),
		.ctrl_i       (ctrl_i),
		.ack_i        (wbm_ack_i),
		.status_i     (wbm_dat_i),
		.all_loaded_i (all_loaded),
		.all_sent_i   (all_sent),
		.req_o        (req),
		.cnt_op_o     (cnt_op),
		.capture_o    (capture),
		.done_o       (done_o),
		.busy_o       (busy_o)
	);

	i2c_byte_counter #(
		.DATA_BYTES (DATA_BYTES)
	) i_i2c_byte_counter (
		.clk          (clk),
		.nrst         (nrst),
		.cnt_op_i     (cnt_op),
		.capture_i    (capture),
		.length_i     (ctrl_i.length),
		.all_loaded_o (all_loaded),
		.all_sent_o   (all_sent)
	);

	// registered bus side
	wb_req_driver #(
		.DATA_BYTES (DATA_BYTES)
	) i_wb_req_driver (
		.clk       (clk),
		.nrst      (nrst),
		.req_i     (req),
		.capture_i (capture),
		.ctrl_i    (ctrl_i),
		.data_i    (data_i),
		.wbm_adr_o (wbm_adr_o),
		.wbm_dat_o (wbm_dat_o),
		.wbm_we_o  (wbm_we_o),
		.wbm_stb_o (wbm_stb_o),
		.wbm_cyc_o (wbm_cyc_o)
	);

endmodule

`default_nettype wire

//--- testbench/i2c_core_model.sv
`timescale 1ns/1ps
`default_nettype none

// i2c master core as seen from its register bus
// acks 1 to 4 cycles after stb, runs a busy sequence per byte, can drop one slave ack
module i2c_core_model
	import i2c_host_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  wb_adr_t     adr_i,
	input  wb_byte_t    dat_i,
	input  logic        we_i,
	input  logic        stb_i,
	input  logic        cyc_i,
	input  logic [31:0] rnd_i,       // new random word each cycle
	input  byte_cnt_t   miss_byte_i, // byte left unacked, 0 for none
	output logic        ack_o,
	output wb_byte_t    dat_o,
	output logic        wr_seen_o,   // one bus write logged
	output wb_adr_t     wr_adr_o,
	output wb_byte_t    wr_dat_o
);

	logic [2:0] ack_wait;   // cycles left to the ack
	wb_byte_t   resp;       // returned with the ack
	byte_cnt_t  byte_idx;   // byte on the wire, from 1
	logic [1:0] phase;      // 0 quiet, 1 before busy, 2 busy
	int         pre_polls;  // status reads before busy shows
	int         busy_polls; // reads that still see busy

	initial begin
		ack_o     = 1'b0;
		dat_o     = '0;
		wr_seen_o = 1'b0;
		wr_adr_o  = '0;
		wr_dat_o  = '0;
		ack_wait  = '0;
		resp      = '0;
	end

	always @(posedge clk) begin : respond
		logic        rst_s;
		logic        stb_s;
		logic        we_s;
		wb_adr_t     adr_s;
		wb_byte_t    dat_s;
		logic [31:0] rnd_s;
		byte_cnt_t   miss_s;

		// bus as it was at the edge
		rst_s  = !nrst;
		stb_s  = stb_i && cyc_i;
		we_s   = we_i;
		adr_s  = adr_i;
		dat_s  = dat_i;
		rnd_s  = rnd_i;
		miss_s = miss_byte_i;
		#2;
		ack_o     = 1'b0;
		wr_seen_o = 1'b0;
		if (rst_s) begin
			ack_wait = '0;
			phase    = '0;
			byte_idx = '0;
		end else if (stb_s) begin
			resp = '0;
			if (we_s) begin
				wr_seen_o = 1'b1;
				wr_adr_o  = adr_s;
				wr_dat_o  = dat_s;
				// start-write or restart puts a new byte on the wire
				if (adr_s == REG_CMD &&
					(dat_s == CMD_START_WRITE || dat_s == CMD_RESTART)) begin
					byte_idx   = (dat_s == CMD_START_WRITE) ? byte_cnt_t'(1) : byte_idx + 1'b1;
					phase      = 2'd1;
					pre_polls  = int'(rnd_s[7:6]) % 3;
					busy_polls = int'(rnd_s[9:8]);
				end
			end else if (phase == 2'd1) begin
				if (pre_polls != 0) begin
					pre_polls--; // not started yet
				end else begin
					resp[STAT_BUSY] = 1'b1;
					phase           = 2'd2;
				end
			end else if (phase == 2'd2) begin
				if (busy_polls != 0) begin
					busy_polls--;
					resp[STAT_BUSY] = 1'b1;
				end else begin
					resp[STAT_MISS_ACK] = (byte_idx == miss_s); // byte finished
					phase               = 2'd0;
				end
			end
			if (ack_wait == 0) begin
				ack_wait = 3'd1 + rnd_s[1:0]; // only one ack in flight
			end
		end
		if (!rst_s && ack_wait != 0) begin
			ack_wait = ack_wait - 1'b1;
			if (ack_wait == 0) begin
				ack_o = 1'b1;
				dat_o = resp;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_i2c_host.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the i2c host sequencer
// directed then random prescale, write and read-only commands against a core model
module tb_i2c_host
	import i2c_host_pkg::*;
();

	localparam int DATA_BYTES = 4;
	localparam int N_RANDOM   = 200;  // random commands after the directed ones
	localparam int TIMEOUT    = 2000; // cycles allowed per write command

	logic                    clk;
	logic                    nrst;
	ctrl_word_t              ctrl;
	logic [DATA_BYTES*8-1:0] data;
	logic                    done;
	logic                    busy;
	wb_adr_t                 adr;
	wb_byte_t                dat_m2s;   // host to core
	wb_byte_t                dat_s2m;   // status back
	logic                    we;
	logic                    stb;
	logic                    ack;
	logic                    cyc;
	logic [31:0]             bus_rnd;   // ack delays and busy lengths
	byte_cnt_t               miss_byte; // 0 means every byte acked
	logic                    wr_seen;
	wb_adr_t                 wr_adr;
	wb_byte_t                wr_dat;

	logic [31:0] lcg_state;
	logic        outstanding; // request on the bus, no ack yet
	int          value_errs;
	int          proto_errs;
	int          timeouts;
	wb_adr_t     exp_adr[$];  // expected write log
	wb_byte_t    exp_dat[$];

	i2c_host_top #(
		.DATA_BYTES (DATA_BYTES)
	) i_i2c_host_top (
		.clk       (clk),
		.nrst      (nrst),
		.ctrl_i    (ctrl),
		.data_i    (data),
		.done_o    (done),
		.busy_o    (busy),
		.wbm_adr_o (adr),
		.wbm_dat_o (dat_m2s),
		.wbm_dat_i (dat_s2m),
		.wbm_we_o  (we),
		.wbm_stb_o (stb),
		.wbm_ack_i (ack),
		.wbm_cyc_o (cyc)
	);

	i2c_core_model i_i2c_core_model (
		.clk         (clk),
		.nrst        (nrst),
		.adr_i       (adr),
		.dat_i       (dat_m2s),
		.we_i        (we),
		.stb_i       (stb),
		.cyc_i       (cyc),
		.rnd_i       (bus_rnd),
		.miss_byte_i (miss_byte),
		.ack_o       (ack),
		.dat_o       (dat_s2m),
		.wr_seen_o   (wr_seen),
		.wr_adr_o    (wr_adr),
		.wr_dat_o    (wr_dat)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_adr(input string name, input wb_adr_t got, input wb_adr_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_byte(input string name, input wb_byte_t got, input wb_byte_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	// inputs change 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
		bus_rnd = next_rand();
	endtask

	task automatic push_write(input wb_adr_t a, input wb_byte_t d);
		exp_adr.push_back(a);
		exp_dat.push_back(d);
	endtask

	// start drops once idle has sampled it
	task automatic issue(input ctrl_word_t c, input logic [DATA_BYTES*8-1:0] d);
		ctrl = c;
		data = d;
		next_cycle();
		ctrl.start = 1'b0;
	endtask

	task automatic check_bus_write(input wb_adr_t a, input wb_byte_t d);
		check_bit("wbm_stb_o", stb, 1'b1);
		check_bit("wbm_we_o", we, 1'b1);
		check_adr("wbm_adr_o", adr, a);
		check_byte("wbm_dat_o", dat_m2s, d);
		check_bit("busy_o", busy, 1'b0);
	endtask

	// bus and flags idle, then every expected write must have shown up
	task automatic quiet_cycles(input int n);
		repeat (n) begin
			next_cycle();
			check_bit("wbm_stb_o", stb, 1'b0);
			check_bit("wbm_cyc_o", cyc, 1'b0);
			check_bit("done_o", done, 1'b0);
			check_bit("busy_o", busy, 1'b0);
		end
		if (exp_adr.size() != 0) begin
			$display("%0d expected bus writes never appeared", exp_adr.size());
			proto_errs++;
			exp_adr.delete();
			exp_dat.delete();
		end
	endtask

	// low then high byte on the two edges after start is sampled
	task automatic run_prescale(input prescale_t p);
		ctrl_word_t c;

		c              = '0;
		c.start        = 1'b1;
		c.set_prescale = 1'b1;
		c.prescale     = p;
		push_write(REG_PRESC_LO, p[7:0]);
		push_write(REG_PRESC_HI, p[15:8]);
		issue(c, '0);
		check_bit("busy_o", busy, 1'b0);
		next_cycle();
		check_bus_write(REG_PRESC_LO, p[7:0]);
		next_cycle();
		check_bus_write(REG_PRESC_HI, p[15:8]);
		next_cycle();
		check_bit("done_o", done, 1'b1);
		check_bit("wbm_stb_o", stb, 1'b0);
		check_bit("wbm_cyc_o", cyc, 1'b0);
		check_bit("busy_o", busy, 1'b0);
		quiet_cycles(6);
	endtask

	task automatic run_write(input slave_addr_t sa, input byte_cnt_t len,
		input logic [31:0] d, input byte_cnt_t miss_at, input logic presc_too);
		ctrl_word_t c;
		int         i;
		int         cycles;
		logic       got_done;
		logic       ended;

		c              = '0;
		c.start        = 1'b1;
		c.wr           = 1'b1;
		c.set_prescale = presc_too; // wr must win
		c.slave_addr   = sa;
		c.length       = len;
		miss_byte      = miss_at;
		push_write(REG_ADDR, {1'b0, sa});
		for (i = 0; i < len; i++) begin
			push_write(REG_DATA, d[8*i +: 8]); // lsb first
		end
		push_write(REG_CMD, CMD_START_WRITE);
		repeat ((miss_at != 0) ? miss_at - 1 : len - 1) push_write(REG_CMD, CMD_RESTART);
		push_write(REG_CMD, CMD_STOP);
		issue(c, d);
		check_bit("busy_o", busy, 1'b1);
		cycles   = 0;
		got_done = 1'b0;
		ended    = 1'b0;
		while (!ended && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
			if (done) begin
				got_done = 1'b1;
				ended    = 1'b1;
			end else if (!busy) begin
				ended = 1'b1; // abort path
			end
		end
		if (!ended) begin
			$display("write command still running after %0d cycles", TIMEOUT);
			timeouts++;
		end else begin
			check_bit("done_o", got_done, miss_at == 0);
		end
		quiet_cycles(6);
	endtask

	// write log and ack ordering
	always @(posedge clk) begin
		if (nrst) begin
			if (wr_seen) begin
				if (exp_adr.size() == 0) begin
					$display("unexpected bus write of %h to register %h", wr_dat, wr_adr);
					proto_errs++;
				end else begin
					check_adr("wbm_adr_o", wr_adr, exp_adr.pop_front());
					check_byte("wbm_dat_o", wr_dat, exp_dat.pop_front());
				end
			end
			if (ack || !cyc) begin
				outstanding = 1'b0;
			end
			if (stb && cyc) begin
				if (!we) begin
					check_adr("wbm_adr_o", adr, REG_STATUS); // status is the only read
				end
				if (outstanding && busy) begin
					$display("request issued before the previous ack");
					proto_errs++;
				end
				outstanding = 1'b1;
			end
		end
	end

	initial begin : stimulus
		int          i;
		logic [31:0] r;
		logic [31:0] r2;
		byte_cnt_t   len;
		byte_cnt_t   miss_at;
		ctrl_word_t  c;

		clk         = 1'b0;
		nrst        = 1'b0;
		ctrl        = '0;
		data        = '0;
		bus_rnd     = '0;
		miss_byte   = '0;
		lcg_state   = 32'd1452;
		outstanding = 1'b0;
		value_errs  = 0;
		proto_errs  = 0;
		timeouts    = 0;
		repeat (3) next_cycle();
		nrst = 1'b1;
		check_bit("wbm_stb_o", stb, 1'b0);
		check_bit("wbm_cyc_o", cyc, 1'b0);
		check_bit("wbm_we_o", we, 1'b0);
		check_bit("done_o", done, 1'b0);
		check_bit("busy_o", busy, 1'b0);

		c       = '0;
		c.start = 1'b1;
		c.rd    = 1'b1; // read alone is ignored
		issue(c, '0);
		quiet_cycles(20);
		run_prescale(16'h1a2b);
		run_write(7'h50, 4'd4, 32'h44332211, 4'd0, 1'b0);
		run_write(7'h2c, 4'd3, 32'h00c0ffee, 4'd2, 1'b0);
		run_write(7'h2c, 4'd2, 32'h0000beef, 4'd0, 1'b1); // runs normally after abort

		for (i = 0; i < N_RANDOM && timeouts == 0; i++) begin
			r       = next_rand();
			r2      = next_rand();
			len     = byte_cnt_t'(r[28:27]) + 1'b1;
			miss_at = (r[26:25] == 2'd0) ? byte_cnt_t'(int'(r[24:23]) % int'(len) + 1) : '0;
			if (r[31:29] == 3'd0) begin
				c            = '0;
				c.start      = 1'b1;
				c.rd         = 1'b1;
				c.slave_addr = r[22:16];
				issue(c, r2);
				quiet_cycles(20);
			end else if (r[31:29] < 3'd3) begin
				run_prescale(r2[31:16]);
			end else begin
				run_write(r[22:16], len, r2, miss_at, r[15]);
			end
		end

		$display("value errors %0d, protocol errors %0d, timeouts %0d",
			value_errs, proto_errs, timeouts);
		if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
common/i2c_host_pkg.sv
rtl/i2c_seq/i2c_seq_fsm.sv
rtl/i2c_seq/i2c_byte_counter.sv
rtl/wb_req_driver.sv
rtl/i2c_host_top.sv
testbench/i2c_core_model.sv
testbench/tb_i2c_host.sv
